// File: cpu.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/operand_bus.sv
verilog/cu.sv
verilog/cpu.sv
verif/cpu_chk.sv
verif/cpu_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f cpu.f --top-module cpu_tb -Mdir obj_dir
	./obj_dir/Vcpu_tb | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: verif/cpu_tb.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_tb
  import cpu_pkg::*;
;

  // six programs of at most about 200 cycles each
  localparam int CYCLE_LIMIT = 3000;
  localparam logic [15:0] MARK = 16'h00ff;

  logic  clk;
  logic  rst;
  logic  en;
  logic  irq;
  logic  mem_rd;
  logic  mem_wr;
  addr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;

  word_t mem [256];
  logic  written [256];
  int    reads [$];
  int    pc_w;
  int    seed;
  int    cycles = 0;
  int    errors = 0;
  int    checks = 0;
  int    tests = 0;

  cpu i_dut (
    .clk(clk), .rst(rst), .en(en), .irq(irq),
    .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

  always #20 clk = ~clk;

  // word memory with same-cycle read and write on the edge
  assign mem_rdata = mem[mem_addr[7:0]];

  always @(posedge clk) begin
    if (mem_wr) begin
      mem[mem_addr[7:0]] <= mem_wdata;
      written[mem_addr[7:0]] <= 1'b1;
    end
  end

  // every read address including fetches
  always @(negedge clk) begin
    if (mem_rd) reads.push_back(int'(mem_addr));
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: no marker store within %0d cycles", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic word_t mem_instr(input logic [3:0] c, input opcode_t op,
                                      input logic [3:0] ra, input logic [15:0] imm);
    return {c, op, ra, imm};
  endfunction

  function automatic word_t rel_instr(input logic [3:0] c, input opcode_t op,
                                      input logic [3:0] ra, input logic [3:0] rb,
                                      input logic [11:0] off);
    return {c, op, ra, rb, off};
  endfunction

  // flags are {immediate, reverse, loadn, set_status}
  function automatic word_t alu_instr(input logic [3:0] c, input logic [3:0] aop,
                                      input logic [3:0] fl, input logic [3:0] ra,
                                      input logic [3:0] rb, input logic [7:0] lo);
    return {c, 4'hf, aop, fl, ra, rb, lo};
  endfunction

  // PC <- imm8 through an ALU pass
  function automatic word_t jump_to(input logic [7:0] target);
    return alu_instr(4'h0, PASS, 4'b1000, PC, R0, target);
  endfunction

  function automatic word_t alu_ref(input int op, input word_t a, input word_t b);
    case (op)
      1: return a + b;
      2: return a - b;
      3: return a & b;
      4: return a | b;
      5: return a ^ b;
      6: return a << b[4:0];
      7: return a >> b[4:0];
      default: return b;
    endcase
  endfunction

  // condition outcome after a - b from plain comparisons
  function automatic logic cond_ref(input int c, input word_t a, input word_t b);
    word_t d;
    logic [32:0] sd;
    d = a - b;
    sd = {a[31], a} - {b[31], b};
    case (c)
      1: return a == b;
      2: return a != b;
      3: return d[31];
      4: return !d[31];
      5: return sd[32] != sd[31];
      6: return sd[32] == sd[31];
      7: return a < b;
      8: return a > b;
      9: return a <= b;
      10: return a >= b;
      11: return $signed(a) < $signed(b);
      12: return $signed(a) > $signed(b);
      13: return $signed(a) <= $signed(b);
      14: return $signed(a) >= $signed(b);
      default: return 1'b1;
    endcase
  endfunction

  function automatic int next_read_after(input int addr);
    for (int i = 0; i + 1 < reads.size(); i++) begin
      if (reads[i] == addr) return reads[i + 1];
    end
    return -1;
  endfunction

  task automatic compare(input string name, input word_t exp, input word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - errs_before);
  endtask

  task automatic clear_mem();
    for (int i = 0; i < 256; i++) begin
      mem[i] <= '0;
      written[i] <= 1'b0;
    end
    pc_w = 0;
  endtask

  task automatic emit(input word_t w);
    mem[pc_w] <= w;
    pc_w++;
  endtask

  task automatic start_cpu();
    @(posedge clk);
    rst <= 1'b1;
    en <= 1'b0;
    irq <= 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    reads.delete();
    @(posedge clk);
    en <= 1'b1;
  endtask

  // a store to MARK ends each program
  task automatic run_to_marker();
    @(negedge clk);
    while (!(mem_wr && mem_addr == MARK)) @(negedge clk);
    @(posedge clk);
    en <= 1'b0;
    @(negedge clk);
  endtask

  task automatic transfers();
    int    e0;
    word_t v;
    e0 = errors;
    v = word_t'($random(seed));
    clear_mem();
    mem[8'h88] <= v;
    emit(mem_instr(4'h0, OP_LDI, R1, 16'h1234));
    emit(mem_instr(4'h0, OP_ST, R1, 16'h0090));
    emit(mem_instr(4'h0, OP_LD, R2, 16'h0088));
    emit(mem_instr(4'h0, OP_ST, R2, 16'h0091));
    emit(mem_instr(4'h0, OP_ST, R0, MARK));
    start_cpu();
    run_to_marker();
    compare("ldi then st", 32'h0000_1234, mem[8'h90]);
    compare("ld then st", v, mem[8'h91]);
    report("transfers", e0);
  endtask

  task automatic alu_forms();
    int         e0;
    int         base;
    word_t      a;
    word_t      b;
    word_t      keep;
    logic [7:0] imm [8];
    e0 = errors;
    a = word_t'($random(seed));
    b = word_t'($random(seed));
    keep = word_t'($random(seed));
    clear_mem();
    mem[8'h80] <= a;
    mem[8'h81] <= b;
    mem[8'h82] <= keep;
    emit(mem_instr(4'h0, OP_LD, R1, 16'h0080));
    emit(mem_instr(4'h0, OP_LD, R2, 16'h0081));
    emit(mem_instr(4'h0, OP_LD, R4, 16'h0082));
    for (int op = 0; op < 8; op++) begin
      imm[op] = 8'($random(seed));
      base = 'ha0 + 4 * op;
      emit(alu_instr(4'h0, op[3:0], 4'b0000, R3, R1, {R2, 4'h0}));
      emit(mem_instr(4'h0, OP_ST, R3, 16'(base)));
      emit(alu_instr(4'h0, op[3:0], 4'b0100, R3, R1, {R2, 4'h0}));
      emit(mem_instr(4'h0, OP_ST, R3, 16'(base + 1)));
      emit(alu_instr(4'h0, op[3:0], 4'b1000, R3, R1, imm[op]));
      emit(mem_instr(4'h0, OP_ST, R3, 16'(base + 2)));
      emit(alu_instr(4'h0, op[3:0], 4'b1100, R3, R1, imm[op]));
      emit(mem_instr(4'h0, OP_ST, R3, 16'(base + 3)));
      // loadn must leave R4 as it was
      emit(alu_instr(4'h0, op[3:0], 4'b0010, R4, R1, {R2, 4'h0}));
    end
    emit(mem_instr(4'h0, OP_ST, R4, 16'h00c0));
    emit(mem_instr(4'h0, OP_ST, R0, MARK));
    start_cpu();
    run_to_marker();
    for (int op = 0; op < 8; op++) begin
      base = 'ha0 + 4 * op;
      compare($sformatf("alu op %0d reg", op), alu_ref(op, a, b), mem[base]);
      compare($sformatf("alu op %0d reg reverse", op), alu_ref(op, b, a), mem[base + 1]);
      compare($sformatf("alu op %0d imm", op), alu_ref(op, a, {24'h0, imm[op]}),
              mem[base + 2]);
      compare($sformatf("alu op %0d imm reverse", op), alu_ref(op, {24'h0, imm[op]}, a),
              mem[base + 3]);
    end
    compare("alu loadn", keep, mem[8'hc0]);
    report("alu forms", e0);
  endtask

  task automatic cond_exec();
    int    e0;
    word_t pa [5];
    word_t pb [5];
    e0 = errors;
    // equal, unsigned below, both signed overflows, random
    pa[0] = 32'd5;
    pb[0] = 32'd5;
    pa[1] = 32'd3;
    pb[1] = 32'd7;
    pa[2] = 32'h7fff_ffff;
    pb[2] = 32'hffff_ffff;
    pa[3] = 32'h8000_0000;
    pb[3] = 32'd1;
    pa[4] = word_t'($random(seed));
    pb[4] = word_t'($random(seed));
    for (int p = 0; p < 5; p++) begin
      clear_mem();
      mem[8'h80] <= pa[p];
      mem[8'h81] <= pb[p];
      emit(mem_instr(4'h0, OP_LD, R1, 16'h0080));
      emit(mem_instr(4'h0, OP_LD, R2, 16'h0081));
      emit(alu_instr(4'h0, SUB, 4'b0011, R3, R1, {R2, 4'h0}));
      for (int c = 0; c < 16; c++) begin
        emit(mem_instr(c[3:0], OP_ST, R1, 16'(8'hc0 + c)));
      end
      emit(mem_instr(4'h0, OP_ST, R0, MARK));
      start_cpu();
      run_to_marker();
      for (int c = 0; c < 16; c++) begin
        compare($sformatf("cond %0d pair %0d", c, p), word_t'(cond_ref(c, pa[p], pb[p])),
                word_t'(written[8'hc0 + c]));
      end
    end
    report("conditional execution", e0);
  endtask

  task automatic reg_indirect();
    int    e0;
    word_t x;
    word_t y;
    e0 = errors;
    x = word_t'($random(seed));
    y = word_t'($random(seed));
    clear_mem();
    // base 0x90 with reads at +5 and -3
    mem[8'h95] <= x;
    mem[8'h8d] <= y;
    emit(mem_instr(4'h0, OP_LDI, R5, 16'h0090));
    emit(rel_instr(4'h0, OP_LDR, R6, R5, 12'h005));
    emit(rel_instr(4'h0, OP_LDR, R7, R5, 12'hffd));
    emit(rel_instr(4'h0, OP_STR, R6, R5, 12'h020));
    emit(rel_instr(4'h0, OP_STR, R7, R5, 12'hff0));
    emit(mem_instr(4'h0, OP_ST, R0, MARK));
    start_cpu();
    run_to_marker();
    compare("ldr str positive offset", x, mem[8'hb0]);
    compare("ldr str negative offset", y, mem[8'h80]);
    report("register indirect", e0);
  endtask

  task automatic traps();
    int    e0;
    word_t ret;
    e0 = errors;
    // PC <- ILR through a register form pass
    ret = alu_instr(4'h0, PASS, 4'b0000, PC, R0, {ILR, 4'h0});
    clear_mem();
    emit(jump_to(8'h10));
    emit(jump_to(8'h10));
    emit(jump_to(8'h20));
    emit(jump_to(8'h30));
    pc_w = 'h10;
    emit(mem_instr(4'h0, OP_INT, R0, 16'h0000));
    emit({4'h0, 8'h07, 20'h0});
    emit(mem_instr(4'h0, OP_ST, R0, MARK));
    pc_w = 'h20;
    emit(mem_instr(4'h0, OP_ST, ILR, 16'h00a0));
    emit(ret);
    pc_w = 'h30;
    emit(mem_instr(4'h0, OP_ST, ILR, 16'h00a1));
    emit(ret);
    start_cpu();
    run_to_marker();
    compare("int vector", `CPU_SWINT_VEC, next_read_after('h10));
    compare("int ilr", 32'h11, mem[8'ha0]);
    compare("undefined vector", `CPU_EXCEPT_VEC, next_read_after('h11));
    compare("undefined ilr", 32'h12, mem[8'ha1]);
    report("software traps", e0);
  endtask

  task automatic hw_interrupt();
    int e0;
    int strobes;
    e0 = errors;
    clear_mem();
    emit(jump_to(8'h10));
    emit(jump_to(8'h40));
    pc_w = 'h10;
    // imask and supervisor mode followed by a run of NOPs
    emit(mem_instr(4'h0, OP_LDI, STATUS, 16'h0030));
    pc_w = 'h20;
    emit(mem_instr(4'h0, OP_ST, R0, MARK));
    pc_w = 'h40;
    emit(mem_instr(4'h0, OP_ST, ILR, 16'h00a2));
    emit(mem_instr(4'h0, OP_ST, R0, MARK));
    start_cpu();
    @(negedge clk);
    while (!(mem_rd && mem_addr == 16'h0013)) @(negedge clk);
    @(posedge clk);
    irq <= 1'b1;
    run_to_marker();
    compare("hwint vector", `CPU_HWINT_VEC, next_read_after('h13));
    compare("hwint ilr", 32'h14, mem[8'ha2]);
    // irq still high while the core is disabled
    repeat (2) @(posedge clk);
    strobes = 0;
    repeat (8) begin
      @(negedge clk);
      if (mem_rd || mem_wr) strobes++;
    end
    compare("strobes with en low", 0, strobes);
    @(posedge clk);
    irq <= 1'b0;
    report("hardware interrupt", e0);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    en = 1'b0;
    irq = 1'b0;
    seed = 7;
    pc_w = 0;
    transfers();
    alu_forms();
    cond_exec();
    reg_indirect();
    traps();
    hw_interrupt();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verif/cpu_chk.sv
`timescale 1ns/1ns

module cpu_chk (
  input logic clk,
  input logic rst,
  input logic en,
  input logic mem_rd,
  input logic mem_wr
);

  // one bus transfer per cycle
  strobe_excl: assert property (@(posedge clk) !(mem_rd && mem_wr))
    else $error("mem_rd and mem_wr high in the same cycle");

  // bus stays quiet right after reset
  quiet_after_rst: assert property (@(posedge clk) rst |=> !(mem_rd || mem_wr))
    else $error("memory strobe in the cycle after reset");

  // enable is registered once, so two low samples guarantee an idle bus
  quiet_when_off: assert property (@(posedge clk) disable iff (rst)
    (!en && !$past(en)) |-> !(mem_rd || mem_wr))
    else $error("memory strobe while the core is disabled");

endmodule

bind cpu cpu_chk u_chk (
  .clk(clk),
  .rst(rst),
  .en(en),
  .mem_rd(mem_rd),
  .mem_wr(mem_wr)
);

// File: verilog/cpu.sv
`timescale 1ns/1ns

module cpu
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  en,
  input  logic  irq,
  output logic  mem_rd,
  output logic  mem_wr,
  output addr_t mem_addr,
  output word_t mem_wdata,
  input  word_t mem_rdata
);

  alu_op_e     alu_op;
  reg_e        sel_a_reg;
  reg_e        sel_b_reg;
  reg_e        sel_in_reg;
  logic        oe_a_reg;
  logic        oe_b_reg;
  logic        oe_a_ir;
  logic        oe_b_ir;
  logic        oe_b_consts;
  logic        a_mask_imm8;
  logic        b_mask_addr;
  logic        use_offset;
  logic        ld_reg;
  logic        load_from_mem;
  logic        ld_ir;
  logic        post_inc_pc;
  logic        ld_ilr_pc;
  logic        ld_alu_status;
  logic        trap;
  word_t       ir;
  word_t       status;
  word_t       a_data;
  word_t       b_data;
  word_t       a_bus;
  word_t       b_bus;
  word_t       alu_result;
  alu_status_t alu_flags;
  word_t       wdata;

  // loads take the bus data, everything else the ALU
  assign wdata = load_from_mem ? mem_rdata : alu_result;
  assign mem_wdata = a_bus;

  cu u_cu (
    .clk(clk), .rst(rst), .en(en), .irq(irq),
    .mem_rdata(mem_rdata), .ir(ir), .status(status),
    .rd(mem_rd), .wr(mem_wr), .alu_op(alu_op),
    .sel_a_reg(sel_a_reg), .sel_b_reg(sel_b_reg), .sel_in_reg(sel_in_reg),
    .oe_a_reg(oe_a_reg), .oe_b_reg(oe_b_reg), .oe_a_ir(oe_a_ir), .oe_b_ir(oe_b_ir),
    .oe_b_consts(oe_b_consts), .a_mask_imm8(a_mask_imm8), .b_mask_addr(b_mask_addr),
    .use_offset(use_offset), .ld_reg(ld_reg), .load_from_mem(load_from_mem),
    .ld_ir(ld_ir), .post_inc_pc(post_inc_pc), .ld_ilr_pc(ld_ilr_pc),
    .ld_alu_status(ld_alu_status), .trap(trap)
  );

  reg_file u_reg_file (
    .clk(clk), .rst(rst),
    .sel_a(sel_a_reg), .sel_b(sel_b_reg), .sel_in(sel_in_reg), .wdata(wdata),
    .ld_reg(ld_reg), .post_inc_pc(post_inc_pc), .ld_ilr_pc(ld_ilr_pc), .trap(trap),
    .ld_alu_status(ld_alu_status), .alu_flags(alu_flags),
    .a_data(a_data), .b_data(b_data), .status(status)
  );

  operand_bus u_operand_bus (
    .clk(clk), .rst(rst), .ld_ir(ld_ir), .mem_rdata(mem_rdata),
    .a_data(a_data), .b_data(b_data),
    .oe_a_reg(oe_a_reg), .oe_b_reg(oe_b_reg), .oe_a_ir(oe_a_ir), .oe_b_ir(oe_b_ir),
    .oe_b_consts(oe_b_consts), .a_mask_imm8(a_mask_imm8), .b_mask_addr(b_mask_addr),
    .use_offset(use_offset), .sel_b_reg(sel_b_reg),
    .ir(ir), .a_bus(a_bus), .b_bus(b_bus), .mem_addr(mem_addr)
  );

  alu u_alu (
    .op(alu_op), .a(a_bus), .b(b_bus),
    .result(alu_result), .flags(alu_flags)
  );

endmodule

// File: verilog/cu.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cu
  import cpu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        en,
  input  logic        irq,
  input  word_t       mem_rdata,
  input  word_t       ir,
  input  word_t       status,
  output logic        rd,
  output logic        wr,
  output alu_op_e     alu_op,
  output reg_e        sel_a_reg,
  output reg_e        sel_b_reg,
  output reg_e        sel_in_reg,
  output logic        oe_a_reg,
  output logic        oe_b_reg,
  output logic        oe_a_ir,
  output logic        oe_b_ir,
  output logic        oe_b_consts,
  output logic        a_mask_imm8,
  output logic        b_mask_addr,
  output logic        use_offset,
  output logic        ld_reg,
  output logic        load_from_mem,
  output logic        ld_ir,
  output logic        post_inc_pc,
  output logic        ld_ilr_pc,
  output logic        ld_alu_status,
  output logic        trap
);

  cu_state_e state;
  cu_state_e next_state;
  logic      sync_en;
  opcode_t   fetch_op;
  cond_e     fetch_cond;
  logic      fetch_go;

  function automatic logic cond_met(input cond_e c, input alu_status_t f);
    logic z;
    logic n;
    logic cy;
    logic v;
    z = f[`CPU_FLAG_Z];
    n = f[`CPU_FLAG_N];
    cy = f[`CPU_FLAG_C];
    v = f[`CPU_FLAG_V];
    case (c)
      EQ:      cond_met = z;
      NE:      cond_met = !z;
      NEG:     cond_met = n;
      POS:     cond_met = !n;
      VS:      cond_met = v;
      VC:      cond_met = !v;
      ULT:     cond_met = !cy;
      UGT:     cond_met = cy && !z;
      ULE:     cond_met = !cy || z;
      UGE:     cond_met = cy;
      SLT:     cond_met = n != v;
      SGT:     cond_met = !z && (n == v);
      SLE:     cond_met = z || (n != v);
      SGE:     cond_met = n == v;
      default: cond_met = 1'b1;
    endcase
  endfunction

  // decode straight off the read data while fetching
  assign fetch_op = mem_rdata[27:20];
  assign fetch_cond = cond_e'(mem_rdata[31:28]);
  assign fetch_go = cond_met(fetch_cond, status[3:0]);

  always_ff @(posedge clk) begin
    if (rst) begin
      sync_en <= 1'b0;
      state <= FETCH;
    end else begin
      sync_en <= en;
      if (sync_en) state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      FETCH: begin
        // failed condition stays here, PC has already moved on
        if (fetch_go) begin
          if (fetch_op[7:4] == 4'hf) next_state = ALU;
          else begin
            case (fetch_op)
              OP_NOP:  next_state = NOP;
              OP_LD:   next_state = LD;
              OP_LDR:  next_state = LDR;
              OP_LDI:  next_state = LDI;
              OP_ST:   next_state = ST;
              OP_STR:  next_state = STR;
              OP_INT:  next_state = SWINT;
              default: next_state = EXCEPT;
            endcase
          end
        end
      end
      // traps clear imask, so never chain into HWINT
      HWINT, SWINT, EXCEPT: next_state = FETCH;
      default: begin
        if (irq && status[`CPU_STATUS_IMASK]) next_state = HWINT;
        else next_state = FETCH;
      end
    endcase
  end

  always_comb begin
    rd = 1'b0;
    wr = 1'b0;
    alu_op = PASS;
    sel_a_reg = R0;
    sel_b_reg = R0;
    sel_in_reg = R0;
    oe_a_reg = 1'b0;
    oe_b_reg = 1'b0;
    oe_a_ir = 1'b0;
    oe_b_ir = 1'b0;
    oe_b_consts = 1'b0;
    a_mask_imm8 = 1'b0;
    b_mask_addr = 1'b0;
    use_offset = 1'b0;
    ld_reg = 1'b0;
    load_from_mem = 1'b0;
    ld_ir = 1'b0;
    post_inc_pc = 1'b0;
    ld_ilr_pc = 1'b0;
    ld_alu_status = 1'b0;
    trap = 1'b0;

    if (sync_en) begin
      case (state)
        // ir <- mem[pc++]
        FETCH: begin
          sel_b_reg = PC;
          oe_b_reg = 1'b1;
          rd = 1'b1;
          ld_ir = 1'b1;
          post_inc_pc = 1'b1;
        end
        // reg_a <- mem[addr]
        LD: begin
          oe_b_ir = 1'b1;
          b_mask_addr = 1'b1;
          rd = 1'b1;
          sel_in_reg = reg_e'(ir[19:16]);
          ld_reg = 1'b1;
          load_from_mem = 1'b1;
        end
        // reg_a <- mem[reg_b + offset]
        LDR: begin
          sel_b_reg = reg_e'(ir[15:12]);
          oe_b_reg = 1'b1;
          use_offset = 1'b1;
          rd = 1'b1;
          sel_in_reg = reg_e'(ir[19:16]);
          ld_reg = 1'b1;
          load_from_mem = 1'b1;
        end
        // reg_a <- imm16
        LDI: begin
          oe_b_ir = 1'b1;
          b_mask_addr = 1'b1;
          sel_in_reg = reg_e'(ir[19:16]);
          ld_reg = 1'b1;
        end
        // mem[addr] <- reg_a
        ST: begin
          sel_a_reg = reg_e'(ir[19:16]);
          oe_a_reg = 1'b1;
          oe_b_ir = 1'b1;
          b_mask_addr = 1'b1;
          wr = 1'b1;
        end
        // mem[reg_b + offset] <- reg_a
        STR: begin
          sel_a_reg = reg_e'(ir[19:16]);
          oe_a_reg = 1'b1;
          sel_b_reg = reg_e'(ir[15:12]);
          oe_b_reg = 1'b1;
          use_offset = 1'b1;
          wr = 1'b1;
        end
        ALU: begin
          if (ir[19]) begin
            // immediate form, reverse puts imm8 on A
            if (ir[18]) begin
              oe_a_ir = 1'b1;
              a_mask_imm8 = 1'b1;
              sel_b_reg = reg_e'(ir[11:8]);
              oe_b_reg = 1'b1;
            end else begin
              sel_a_reg = reg_e'(ir[11:8]);
              oe_a_reg = 1'b1;
              oe_b_ir = 1'b1;
            end
          end else begin
            sel_a_reg = ir[18] ? reg_e'(ir[7:4]) : reg_e'(ir[11:8]);
            sel_b_reg = ir[18] ? reg_e'(ir[11:8]) : reg_e'(ir[7:4]);
            oe_a_reg = 1'b1;
            oe_b_reg = 1'b1;
          end
          alu_op = alu_op_e'(ir[23:20]);
          sel_in_reg = reg_e'(ir[15:12]);
          ld_reg = !ir[17];
          ld_alu_status = ir[16];
        end
        // ILR <- PC, PC <- vector, supervisor mode
        HWINT, SWINT, EXCEPT: begin
          if (state == HWINT) sel_b_reg = reg_e'(`CPU_HWINT_VEC);
          else if (state == SWINT) sel_b_reg = reg_e'(`CPU_SWINT_VEC);
          else sel_b_reg = reg_e'(`CPU_EXCEPT_VEC);
          oe_b_consts = 1'b1;
          ld_ilr_pc = 1'b1;
          trap = 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: verilog/operand_bus.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module operand_bus
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  ld_ir,
  input  word_t mem_rdata,
  input  word_t a_data,
  input  word_t b_data,
  input  logic  oe_a_reg,
  input  logic  oe_b_reg,
  input  logic  oe_a_ir,
  input  logic  oe_b_ir,
  input  logic  oe_b_consts,
  input  logic  a_mask_imm8,
  input  logic  b_mask_addr,
  input  logic  use_offset,
  input  reg_e  sel_b_reg,
  output word_t ir,
  output word_t a_bus,
  output word_t b_bus,
  output addr_t mem_addr
);

  offset_t ir_offset;
  word_t   offset_ext;
  word_t   a_ir_val;
  word_t   b_ir_val;
  word_t   addr_sum;

  always_ff @(posedge clk) begin
    if (rst) ir <= '0;
    else if (ld_ir) ir <= mem_rdata;
  end

  assign a_ir_val = a_mask_imm8 ? (ir & `CPU_IMM8_MASK) : ir;
  // imm16 for LD/LDI/ST, otherwise the ALU imm8
  assign b_ir_val = b_mask_addr ? (ir & `CPU_ADDR_MASK) : (ir & `CPU_IMM8_MASK);

  always_comb begin
    if (oe_a_reg) a_bus = a_data;
    else if (oe_a_ir) a_bus = a_ir_val;
    else a_bus = '0;
  end

  always_comb begin
    if (oe_b_reg) b_bus = b_data;
    else if (oe_b_ir) b_bus = b_ir_val;
    else if (oe_b_consts) b_bus = word_t'(sel_b_reg);
    else b_bus = '0;
  end

  // base plus sign-extended offset, cut to the bus width
  assign ir_offset = ir[`CPU_OFFSET_W-1:0];
  assign offset_ext = {{(`CPU_WORD_W - `CPU_OFFSET_W){ir_offset[`CPU_OFFSET_W-1]}}, ir_offset};
  assign addr_sum = b_bus + (use_offset ? offset_ext : '0);
  assign mem_addr = addr_sum[`CPU_ADDR_W-1:0];

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module reg_file
  import cpu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  reg_e        sel_a,
  input  reg_e        sel_b,
  input  reg_e        sel_in,
  input  word_t       wdata,
  input  logic        ld_reg,
  input  logic        post_inc_pc,
  input  logic        ld_ilr_pc,
  input  logic        trap,
  input  logic        ld_alu_status,
  input  alu_status_t alu_flags,
  output word_t       a_data,
  output word_t       b_data,
  output word_t       status
);

  word_t regs [`CPU_NUM_REGS];

  assign a_data = regs[sel_a];
  assign b_data = regs[sel_b];
  assign status = regs[STATUS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) regs[i] <= '0;
      regs[STATUS][`CPU_STATUS_MODE] <= SUPERVISOR;
    end else begin
      // general registers
      if (ld_reg && sel_in <= R12) regs[sel_in] <= wdata;

      if (ld_reg && sel_in == ILR) regs[ILR] <= wdata;
      else if (ld_ilr_pc) regs[ILR] <= regs[PC];

      // a write and the trap vector both arrive on wdata and beat the increment
      if ((ld_reg && sel_in == PC) || trap) regs[PC] <= wdata;
      else if (post_inc_pc) regs[PC] <= regs[PC] + 1'b1;

      if (ld_reg && sel_in == STATUS) begin
        regs[STATUS] <= wdata;
      end else begin
        if (ld_alu_status) regs[STATUS][3:0] <= alu_flags;
        if (trap) begin
          regs[STATUS][`CPU_STATUS_IMASK] <= 1'b0;
          regs[STATUS][`CPU_STATUS_MODE] <= SUPERVISOR;
        end
      end
    end
  end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module alu
  import cpu_pkg::*;
(
  input  alu_op_e     op,
  input  word_t       a,
  input  word_t       b,
  output word_t       result,
  output alu_status_t flags
);

  // one extra bit to catch carry out
  logic [`CPU_WORD_W:0] sum;
  logic                 carry;
  logic                 ovf;

  always_comb begin
    sum = '0;
    result = b;
    carry = 1'b0;
    ovf = 1'b0;
    case (op)
      ADD: begin
        sum = {1'b0, a} + {1'b0, b};
        result = sum[`CPU_WORD_W-1:0];
        carry = sum[`CPU_WORD_W];
        ovf = (a[`CPU_WORD_W-1] == b[`CPU_WORD_W-1]) &&
              (result[`CPU_WORD_W-1] != a[`CPU_WORD_W-1]);
      end
      SUB: begin
        // a + ~b + 1, carry set means no borrow
        sum = {1'b0, a} + {1'b0, ~b} + 1'b1;
        result = sum[`CPU_WORD_W-1:0];
        carry = sum[`CPU_WORD_W];
        ovf = (a[`CPU_WORD_W-1] != b[`CPU_WORD_W-1]) &&
              (result[`CPU_WORD_W-1] != a[`CPU_WORD_W-1]);
      end
      AND: result = a & b;
      OR:  result = a | b;
      XOR: result = a ^ b;
      SHL: result = a << b[4:0];
      SHR: result = a >> b[4:0];
      default: result = b;
    endcase
  end

  assign flags[`CPU_FLAG_Z] = (result == '0);
  assign flags[`CPU_FLAG_N] = result[`CPU_WORD_W-1];
  assign flags[`CPU_FLAG_C] = carry;
  assign flags[`CPU_FLAG_V] = ovf;

endmodule

// File: verilog/cpu_pkg.sv
`include "cpu_consts.svh"

// instruction word layout
//   [31:28] condition, [27:20] opcode
//   LD/LDI/ST: [19:16] reg_a, [15:0] address or immediate
//   LDR/STR:   [19:16] reg_a, [15:12] reg_b, [11:0] signed offset
//   ALU:       [19:16] flags {immediate, reverse, loadn, set_status}
//              [15:12] reg_a (dest), [11:8] reg_b
//              register form [7:4] reg_c, immediate form [7:0] imm8
// STATUS: [3:0] flags, [4] imask, [5] mode
package cpu_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [`CPU_ADDR_W-1:0] addr_t;
  typedef logic signed [`CPU_OFFSET_W-1:0] offset_t;
  typedef logic [7:0] opcode_t;

  // {zero, negative, carry, overflow}
  typedef logic [3:0] alu_status_t;

  typedef enum logic [3:0] {
    R0, R1, R2, R3, R4, R5, R6, R7, R8, R9, R10, R11, R12,
    ILR, STATUS, PC
  } reg_e;

  // code 15 is unnamed and always executes, like NONE
  typedef enum logic [3:0] {
    NONE, EQ, NE, NEG, POS, VS, VC, ULT, UGT, ULE, UGE, SLT, SGT, SLE, SGE
  } cond_e;

  // codes 8 to 15 fall back to PASS
  typedef enum logic [3:0] {
    PASS, ADD, SUB, AND, OR, XOR, SHL, SHR
  } alu_op_e;

  typedef enum logic {
    USER = 1'b0,
    SUPERVISOR = 1'b1
  } cpu_mode_e;

  typedef enum logic [3:0] {
    FETCH, NOP, LD, LDR, LDI, ST, STR, ALU, HWINT, SWINT, EXCEPT
  } cu_state_e;

  localparam opcode_t OP_NOP = 8'h00;
  localparam opcode_t OP_LD = 8'h01;
  localparam opcode_t OP_LDR = 8'h02;
  localparam opcode_t OP_LDI = 8'h03;
  localparam opcode_t OP_ST = 8'h04;
  localparam opcode_t OP_STR = 8'h05;
  localparam opcode_t OP_INT = 8'h06;

endpackage

// File: verilog/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath widths
`define CPU_WORD_W 32
`define CPU_ADDR_W 16
`define CPU_OFFSET_W 12
`define CPU_NUM_REGS 16

// fixed trap vectors, loaded into PC
`define CPU_HWINT_VEC 1
`define CPU_SWINT_VEC 2
`define CPU_EXCEPT_VEC 3

// immediate masks applied to the instruction word
`define CPU_ADDR_MASK 32'h0000_ffff
`define CPU_IMM8_MASK 32'h0000_00ff

// flag bits inside alu_status_t and STATUS
`define CPU_FLAG_Z 3
`define CPU_FLAG_N 2
`define CPU_FLAG_C 1
`define CPU_FLAG_V 0
`define CPU_STATUS_IMASK 4
`define CPU_STATUS_MODE 5

`endif
